// ==== Makefile ====
TOP := odd_pipe_tb
BIN := obj_dir/V$(TOP)
SRCS := $(shell cat compile.f)

.PHONY: all run clean

all: run

$(BIN): compile.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f compile.f

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
hw/odd_pipe_pkg.sv
hw/odd_result_if.sv
hw/permute_unit.sv
hw/local_store.sv
hw/result_delay.sv
hw/odd_pipe.sv
sim/odd_pipe_tb.sv

// ==== hw/local_store.sv ====
// Local store with address generation and a registered load or store result
`timescale 1ns/1ps

module local_store #(
    parameter int LS_ADDR_BITS = 12
) (
    input  logic clk,
    input  logic reset,
    input  odd_pipe_pkg::op_t opcode,
    input  logic [0:odd_pipe_pkg::QUADWORD-1] ra,
    input  logic [0:odd_pipe_pkg::QUADWORD-1] rb,
    input  logic [0:odd_pipe_pkg::QUADWORD-1] rc,
    input  logic [0:odd_pipe_pkg::IMM10_WIDTH-1] imm10,
    input  logic [0:odd_pipe_pkg::IMM16_WIDTH-1] imm16,
    input  logic [0:odd_pipe_pkg::REG_ADDR_WIDTH-1] rt_addr,
    input  logic [0:odd_pipe_pkg::UNIT_ID_WIDTH-1] unit_id,
    odd_result_if.source result
);

    localparam int LINES = 1 << (LS_ADDR_BITS - 4);

    logic [0:odd_pipe_pkg::QUADWORD-1] mem [0:LINES-1];

    logic [0:odd_pipe_pkg::WORD-1] d_addr;
    logic [0:odd_pipe_pkg::WORD-1] x_addr;
    logic [0:odd_pipe_pkg::WORD-1] a_addr;
    logic [0:odd_pipe_pkg::WORD-1] lsa;
    logic [0:LS_ADDR_BITS-5] line;
    logic is_load;
    logic is_store;

    odd_pipe_pkg::result_t res_q;

    // Preferred word of each register holds the address operand
    assign d_addr = {{18{imm10[0]}}, imm10, 4'd0} + ra[0:odd_pipe_pkg::WORD-1];
    assign x_addr = ra[0:odd_pipe_pkg::WORD-1] + rb[0:odd_pipe_pkg::WORD-1];
    assign a_addr = {{14{imm16[0]}}, imm16, 2'd0};

    always_comb begin
        lsa = '0;
        is_load = 1'b0;
        is_store = 1'b0;
        case (opcode)
            odd_pipe_pkg::LQD: begin
                lsa = d_addr;
                is_load = 1'b1;
            end
            odd_pipe_pkg::LQX: begin
                lsa = x_addr;
                is_load = 1'b1;
            end
            odd_pipe_pkg::LQA: begin
                lsa = a_addr;
                is_load = 1'b1;
            end
            odd_pipe_pkg::STQD: begin
                lsa = d_addr;
                is_store = 1'b1;
            end
            odd_pipe_pkg::STQX: begin
                lsa = x_addr;
                is_store = 1'b1;
            end
            odd_pipe_pkg::STQA: begin
                lsa = a_addr;
                is_store = 1'b1;
            end
            default: ;
        endcase
    end

    // Drop the byte offset and wrap to the store size
    assign line = lsa[odd_pipe_pkg::WORD-LS_ADDR_BITS : odd_pipe_pkg::WORD-5];

    always_ff @(posedge clk) begin
        if (is_store) begin
            mem[line] <= rc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_q <= '0;
        end else if (is_load) begin
            res_q.unit_id <= unit_id;
            res_q.wr_en <= 1'b1;
            res_q.rt_addr <= rt_addr;
            res_q.data <= mem[line];
        end else if (is_store) begin
            // Stored value travels down the pipe without a register write
            res_q.unit_id <= unit_id;
            res_q.wr_en <= 1'b0;
            res_q.rt_addr <= rt_addr;
            res_q.data <= rc;
        end else begin
            res_q <= '0;
        end
    end

    assign result.unit_id = res_q.unit_id;
    assign result.wr_en = res_q.wr_en;
    assign result.rt_addr = res_q.rt_addr;
    assign result.data = res_q.data;

endmodule

// ==== hw/odd_pipe.sv ====
// Odd pipe top level with a permute path and a load/store path at fixed latencies
`timescale 1ns/1ps

module odd_pipe #(
    parameter int LS_ADDR_BITS = 12
) (
    input  logic clk,
    input  logic reset,
    input  odd_pipe_pkg::op_t opcode,
    input  logic [0:odd_pipe_pkg::QUADWORD-1] ra,
    input  logic [0:odd_pipe_pkg::QUADWORD-1] rb,
    input  logic [0:odd_pipe_pkg::QUADWORD-1] rc,
    input  logic [0:odd_pipe_pkg::IMM7_WIDTH-1] imm7,
    input  logic [0:odd_pipe_pkg::IMM10_WIDTH-1] imm10,
    input  logic [0:odd_pipe_pkg::IMM16_WIDTH-1] imm16,
    input  logic [0:odd_pipe_pkg::REG_ADDR_WIDTH-1] rt_addr,
    input  logic [0:odd_pipe_pkg::UNIT_ID_WIDTH-1] unit_id,
    output logic [0:odd_pipe_pkg::UNIT_ID_WIDTH-1] perm_unit_id,
    output logic perm_wr_en,
    output logic [0:odd_pipe_pkg::REG_ADDR_WIDTH-1] perm_rt_addr,
    output logic [0:odd_pipe_pkg::QUADWORD-1] perm_data,
    output logic [0:odd_pipe_pkg::UNIT_ID_WIDTH-1] ls_unit_id,
    output logic ls_wr_en,
    output logic [0:odd_pipe_pkg::REG_ADDR_WIDTH-1] ls_rt_addr,
    output logic [0:odd_pipe_pkg::QUADWORD-1] ls_data
);

    logic perm_active;

    odd_result_if perm_issue ();
    odd_result_if ls_issue ();
    odd_result_if perm_out ();
    odd_result_if ls_out ();

    // Unit select for the permute group
    always_comb begin
        case (opcode)
            odd_pipe_pkg::SHLQBI,
            odd_pipe_pkg::SHLQBII,
            odd_pipe_pkg::SHLQBY,
            odd_pipe_pkg::SHLQBYI,
            odd_pipe_pkg::SHLQBYBI,
            odd_pipe_pkg::ROTQBY,
            odd_pipe_pkg::ROTQBYI,
            odd_pipe_pkg::ROTQBI,
            odd_pipe_pkg::ROTQBII,
            odd_pipe_pkg::SHUFB: perm_active = 1'b1;
            default: perm_active = 1'b0;
        endcase
    end

    permute_unit u_permute (
        .opcode(opcode),
        .ra(ra),
        .rb(rb),
        .rc(rc),
        .imm7(imm7),
        .rt_addr(rt_addr),
        .unit_id(unit_id),
        .active(perm_active),
        .result(perm_issue.source)
    );

    local_store #(
        .LS_ADDR_BITS(LS_ADDR_BITS)
    ) u_local_store (
        .clk(clk),
        .reset(reset),
        .opcode(opcode),
        .ra(ra),
        .rb(rb),
        .rc(rc),
        .imm10(imm10),
        .imm16(imm16),
        .rt_addr(rt_addr),
        .unit_id(unit_id),
        .result(ls_issue.source)
    );

    result_delay #(
        .DEPTH(odd_pipe_pkg::PERM_LATENCY)
    ) perm_delay (
        .clk(clk),
        .reset(reset),
        .in_res(perm_issue.sink),
        .out_res(perm_out.source)
    );

    // Local store already holds the first stage
    result_delay #(
        .DEPTH(odd_pipe_pkg::LS_LATENCY - 1)
    ) ls_delay (
        .clk(clk),
        .reset(reset),
        .in_res(ls_issue.sink),
        .out_res(ls_out.source)
    );

    assign perm_unit_id = perm_out.unit_id;
    assign perm_wr_en = perm_out.wr_en;
    assign perm_rt_addr = perm_out.rt_addr;
    assign perm_data = perm_out.data;

    assign ls_unit_id = ls_out.unit_id;
    assign ls_wr_en = ls_out.wr_en;
    assign ls_rt_addr = ls_out.rt_addr;
    assign ls_data = ls_out.data;

endmodule

// ==== hw/odd_pipe_pkg.sv ====
// Odd pipe package with widths, opcodes, the tagged result type and path latencies
package odd_pipe_pkg;

    // Datapath widths
    parameter int QUADWORD = 128;
    parameter int WORD = 32;
    parameter int BYTE = 8;

    // Instruction fields
    parameter int REG_ADDR_WIDTH = 7;
    parameter int UNIT_ID_WIDTH = 3;
    parameter int IMM7_WIDTH = 7;
    parameter int IMM10_WIDTH = 10;
    parameter int IMM16_WIDTH = 16;

    // Fixed issue-to-writeback latencies
    parameter int PERM_LATENCY = 3;
    parameter int LS_LATENCY = 6;

    typedef enum logic [4:0] {
        NOP,
        // Permute group
        SHLQBI,
        SHLQBII,
        SHLQBY,
        SHLQBYI,
        SHLQBYBI,
        ROTQBY,
        ROTQBYI,
        ROTQBI,
        ROTQBII,
        SHUFB,
        // Load/store group
        LQD,
        LQX,
        LQA,
        STQD,
        STQX,
        STQA
    } op_t;

    // Tagged write-back result with big-endian fields
    typedef struct packed {
        logic [0:UNIT_ID_WIDTH-1] unit_id;
        logic wr_en;
        logic [0:REG_ADDR_WIDTH-1] rt_addr;
        logic [0:QUADWORD-1] data;
    } result_t;

endpackage

// ==== hw/odd_result_if.sv ====
// Odd result interface carrying one tagged write-back result between blocks
`timescale 1ns/1ps

interface odd_result_if;

    logic [0:odd_pipe_pkg::UNIT_ID_WIDTH-1] unit_id;
    logic wr_en;
    logic [0:odd_pipe_pkg::REG_ADDR_WIDTH-1] rt_addr;
    // Load data, permute result or stored value
    logic [0:odd_pipe_pkg::QUADWORD-1] data;

    modport source (
        output unit_id,
        output wr_en,
        output rt_addr,
        output data
    );

    modport sink (
        input unit_id,
        input wr_en,
        input rt_addr,
        input data
    );

endinterface

// ==== hw/permute_unit.sv ====
// Permute unit doing quadword shifts, rotates and byte shuffle in one combinational step
`timescale 1ns/1ps

module permute_unit (
    input  odd_pipe_pkg::op_t opcode,
    input  logic [0:odd_pipe_pkg::QUADWORD-1] ra,
    input  logic [0:odd_pipe_pkg::QUADWORD-1] rb,
    input  logic [0:odd_pipe_pkg::QUADWORD-1] rc,
    input  logic [0:odd_pipe_pkg::IMM7_WIDTH-1] imm7,
    input  logic [0:odd_pipe_pkg::REG_ADDR_WIDTH-1] rt_addr,
    input  logic [0:odd_pipe_pkg::UNIT_ID_WIDTH-1] unit_id,
    input  logic active,
    odd_result_if.source result
);

    // Shift amount in bits; byte counts are scaled by eight
    logic [7:0] amt;
    logic rotate;
    logic shuffle;

    logic [0:odd_pipe_pkg::QUADWORD-1] shifted;
    logic [0:odd_pipe_pkg::QUADWORD-1] wrapped;
    logic [0:odd_pipe_pkg::QUADWORD-1] shuf_data;
    logic [0:odd_pipe_pkg::QUADWORD-1] perm_data;
    logic [0:2*odd_pipe_pkg::QUADWORD-1] cat;

    always_comb begin
        amt = '0;
        rotate = 1'b0;
        shuffle = 1'b0;
        case (opcode)
            odd_pipe_pkg::SHLQBI: amt = {5'd0, rb[29:31]};
            odd_pipe_pkg::SHLQBII: amt = {5'd0, imm7[4:6]};
            odd_pipe_pkg::SHLQBY: amt = {rb[27:31], 3'd0};
            odd_pipe_pkg::SHLQBYI: amt = {imm7[2:6], 3'd0};
            odd_pipe_pkg::SHLQBYBI: amt = {rb[24:28], 3'd0};
            odd_pipe_pkg::ROTQBI: begin
                amt = {5'd0, rb[29:31]};
                rotate = 1'b1;
            end
            odd_pipe_pkg::ROTQBII: begin
                amt = {5'd0, imm7[4:6]};
                rotate = 1'b1;
            end
            odd_pipe_pkg::ROTQBY: begin
                amt = {1'b0, rb[28:31], 3'd0};
                rotate = 1'b1;
            end
            odd_pipe_pkg::ROTQBYI: begin
                amt = {1'b0, imm7[3:6], 3'd0};
                rotate = 1'b1;
            end
            odd_pipe_pkg::SHUFB: shuffle = 1'b1;
            default: ;
        endcase
    end

    // Bit 0 is leftmost, so a left shift moves bit i+s into bit i
    // Counts of 128 or more drain to zero
    assign shifted = ra << amt;

    // Bits pushed out on the left come back on the right
    assign wrapped = ra >> (8'd128 - amt);

    assign cat = {ra, rb};

    always_comb begin
        logic [0:odd_pipe_pkg::BYTE-1] ctl;
        shuf_data = '0;
        for (int j = 0; j < odd_pipe_pkg::QUADWORD / odd_pipe_pkg::BYTE; j++) begin
            ctl = rc[odd_pipe_pkg::BYTE*j +: odd_pipe_pkg::BYTE];
            if (ctl[0:1] == 2'b10) begin
                shuf_data[odd_pipe_pkg::BYTE*j +: odd_pipe_pkg::BYTE] = 8'h00;
            end else if (ctl[0:2] == 3'b110) begin
                shuf_data[odd_pipe_pkg::BYTE*j +: odd_pipe_pkg::BYTE] = 8'hff;
            end else if (ctl[0:2] == 3'b111) begin
                shuf_data[odd_pipe_pkg::BYTE*j +: odd_pipe_pkg::BYTE] = 8'h80;
            end else begin
                // Byte 0..15 from ra, 16..31 from rb
                shuf_data[odd_pipe_pkg::BYTE*j +: odd_pipe_pkg::BYTE] =
                    cat[odd_pipe_pkg::BYTE*ctl[3:7] +: odd_pipe_pkg::BYTE];
            end
        end
    end

    always_comb begin
        if (shuffle) begin
            perm_data = shuf_data;
        end else if (rotate) begin
            perm_data = shifted | wrapped;
        end else begin
            perm_data = shifted;
        end
    end

    // Idle cycles leave an all-zero result
    assign result.wr_en = active;
    assign result.unit_id = active ? unit_id : '0;
    assign result.rt_addr = active ? rt_addr : '0;
    assign result.data = active ? perm_data : '0;

endmodule

// ==== hw/result_delay.sv ====
// Result delay line staging tagged results for a fixed number of cycles
`timescale 1ns/1ps

module result_delay #(
    parameter int DEPTH = 3
) (
    input  logic clk,
    input  logic reset,
    odd_result_if.sink in_res,
    odd_result_if.source out_res
);

    odd_pipe_pkg::result_t stages [0:DEPTH-1];
    odd_pipe_pkg::result_t in_word;

    assign in_word = {in_res.unit_id, in_res.wr_en, in_res.rt_addr, in_res.data};

    // One result enters every cycle and several are in flight
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= in_word;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign out_res.unit_id = stages[DEPTH-1].unit_id;
    assign out_res.wr_en = stages[DEPTH-1].wr_en;
    assign out_res.rt_addr = stages[DEPTH-1].rt_addr;
    assign out_res.data = stages[DEPTH-1].data;

endmodule

// ==== sim/odd_pipe_tb.sv ====
// Odd pipe testbench applying an instruction table and checking both result paths
`timescale 1ns/1ps

module odd_pipe_tb;

    localparam int QW = odd_pipe_pkg::QUADWORD;

    logic clk;
    logic reset;
    odd_pipe_pkg::op_t opcode;
    logic [0:QW-1] ra;
    logic [0:QW-1] rb;
    logic [0:QW-1] rc;
    logic [0:odd_pipe_pkg::IMM7_WIDTH-1] imm7;
    logic [0:odd_pipe_pkg::IMM10_WIDTH-1] imm10;
    logic [0:odd_pipe_pkg::IMM16_WIDTH-1] imm16;
    logic [0:odd_pipe_pkg::REG_ADDR_WIDTH-1] rt_addr;
    logic [0:odd_pipe_pkg::UNIT_ID_WIDTH-1] unit_id;
    logic [0:odd_pipe_pkg::UNIT_ID_WIDTH-1] perm_unit_id;
    logic perm_wr_en;
    logic [0:odd_pipe_pkg::REG_ADDR_WIDTH-1] perm_rt_addr;
    logic [0:QW-1] perm_data;
    logic [0:odd_pipe_pkg::UNIT_ID_WIDTH-1] ls_unit_id;
    logic ls_wr_en;
    logic [0:odd_pipe_pkg::REG_ADDR_WIDTH-1] ls_rt_addr;
    logic [0:QW-1] ls_data;

    // Instruction table
    string tab_name[$];
    odd_pipe_pkg::op_t tab_op[$];
    logic [0:QW-1] tab_ra[$];
    logic [0:QW-1] tab_rb[$];
    logic [0:QW-1] tab_rc[$];
    logic [0:6] tab_imm7[$];
    logic [0:9] tab_imm10[$];
    logic [0:15] tab_imm16[$];
    logic [0:QW-1] tab_exp[$];

    odd_pipe_pkg::result_t perm_q[$];
    odd_pipe_pkg::result_t ls_q[$];
    string perm_names[$];
    string ls_names[$];
    int errors;
    int checks;
    int cycles = 0;
    int cycle_limit;
    logic [31:0] lfsr_state;

    odd_pipe #(
        .LS_ADDR_BITS(12)
    ) u_dut (
        .clk(clk),
        .reset(reset),
        .opcode(opcode),
        .ra(ra),
        .rb(rb),
        .rc(rc),
        .imm7(imm7),
        .imm10(imm10),
        .imm16(imm16),
        .rt_addr(rt_addr),
        .unit_id(unit_id),
        .perm_unit_id(perm_unit_id),
        .perm_wr_en(perm_wr_en),
        .perm_rt_addr(perm_rt_addr),
        .perm_data(perm_data),
        .ls_unit_id(ls_unit_id),
        .ls_wr_en(ls_wr_en),
        .ls_rt_addr(ls_rt_addr),
        .ls_data(ls_data)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [0:QW-1] random_quad();
        logic [0:QW-1] q;
        for (int i = 0; i < QW; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            q[i] = lfsr_state[0];
        end
        return q;
    endfunction

    function automatic logic [0:QW-1] word0(input logic [31:0] w);
        return {w, 96'h0};
    endfunction

    // Bit i takes bit i+s and wraps or zero-fills past bit 127
    function automatic logic [0:QW-1] shift_model(input logic [0:QW-1] v, input int s,
                                                   input bit wrap);
        logic [0:QW-1] r;
        for (int i = 0; i < QW; i++) begin
            if (i + s < QW) begin
                r[i] = v[i + s];
            end else begin
                r[i] = wrap ? v[(i + s) % QW] : 1'b0;
            end
        end
        return r;
    endfunction

    // Count in bits taken from each opcode's count field
    function automatic int shift_count(input odd_pipe_pkg::op_t op, input logic [0:QW-1] b,
                                       input logic [0:6] i7);
        case (op)
            odd_pipe_pkg::SHLQBI, odd_pipe_pkg::ROTQBI: return int'(b[29:31]);
            odd_pipe_pkg::SHLQBII, odd_pipe_pkg::ROTQBII: return int'(i7[4:6]);
            odd_pipe_pkg::SHLQBY: return 8 * int'(b[27:31]);
            odd_pipe_pkg::SHLQBYI: return 8 * int'(i7[2:6]);
            odd_pipe_pkg::SHLQBYBI: return 8 * int'(b[24:28]);
            odd_pipe_pkg::ROTQBY: return 8 * int'(b[28:31]);
            odd_pipe_pkg::ROTQBYI: return 8 * int'(i7[3:6]);
            default: return 0;
        endcase
    endfunction

    function automatic bit is_perm_op(input odd_pipe_pkg::op_t op);
        return op >= odd_pipe_pkg::SHLQBI && op <= odd_pipe_pkg::SHUFB;
    endfunction

    function automatic bit is_load_op(input odd_pipe_pkg::op_t op);
        return op >= odd_pipe_pkg::LQD && op <= odd_pipe_pkg::LQA;
    endfunction

    function automatic bit is_store_op(input odd_pipe_pkg::op_t op);
        return op >= odd_pipe_pkg::STQD && op <= odd_pipe_pkg::STQA;
    endfunction

    task automatic add_entry(input string name, input odd_pipe_pkg::op_t op,
                             input logic [0:QW-1] a, input logic [0:QW-1] b,
                             input logic [0:QW-1] c, input logic [0:6] i7,
                             input logic [0:9] i10, input logic [0:15] i16,
                             input logic [0:QW-1] exp);
        tab_name.push_back(name);
        tab_op.push_back(op);
        tab_ra.push_back(a);
        tab_rb.push_back(b);
        tab_rc.push_back(c);
        tab_imm7.push_back(i7);
        tab_imm10.push_back(i10);
        tab_imm16.push_back(i16);
        tab_exp.push_back(exp);
    endtask

    // Shift or rotate of LFSR operands checked against the bit model
    task automatic add_lfsr(input string name, input odd_pipe_pkg::op_t op, input logic [0:6] i7);
        logic [0:QW-1] a;
        logic [0:QW-1] b;
        bit wrap;
        a = random_quad();
        b = random_quad();
        wrap = op >= odd_pipe_pkg::ROTQBY && op <= odd_pipe_pkg::ROTQBII;
        add_entry(name, op, a, b, '0, i7, '0, '0, shift_model(a, shift_count(op, b, i7), wrap));
    endtask

    task automatic build_table();
        logic [0:QW-1] pat_a;
        logic [0:QW-1] pat_b;
        logic [0:QW-1] c1;
        logic [0:QW-1] c2;
        logic [0:QW-1] c3;
        pat_a = 128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff;
        pat_b = 128'h0102_0304_0506_0708_090a_0b0c_0d0e_0f10;
        c1 = 128'h1111_2222_3333_4444_5555_6666_7777_8888;
        c2 = 128'ha5a5_5a5a_c3c3_3c3c_9696_6969_f00f_0ff0;
        c3 = 128'h0f1e_2d3c_4b5a_6978_8796_a5b4_c3d2_e1f0;
        add_entry("shlqbi_reg", odd_pipe_pkg::SHLQBI, pat_a, word0(32'hc), '0, '0, '0, '0,
                  128'h0112_2334_4556_6778_899a_abbc_cdde_eff0);
        add_entry("shlqbii_imm", odd_pipe_pkg::SHLQBII,
                  128'h8000_0000_0000_0000_0000_0000_0000_0011,
                  '0, '0, 7'h0b, '0, '0, 128'h0000_0000_0000_0000_0000_0000_0000_0088);
        add_entry("shlqby_reg", odd_pipe_pkg::SHLQBY, pat_a, word0(32'h23), '0, '0, '0, '0,
                  128'h3344_5566_7788_99aa_bbcc_ddee_ff00_0000);
        add_entry("shlqby_16", odd_pipe_pkg::SHLQBY, pat_a, word0(32'h10), '0, '0, '0, '0, '0);
        add_entry("shlqbyi_imm", odd_pipe_pkg::SHLQBYI, pat_a, '0, '0, 7'h05, '0, '0,
                  128'h5566_7788_99aa_bbcc_ddee_ff00_0000_0000);
        add_entry("shlqbybi_reg", odd_pipe_pkg::SHLQBYBI, pat_a, word0(32'h17), '0, '0, '0, '0,
                  128'h2233_4455_6677_8899_aabb_ccdd_eeff_0000);
        add_lfsr("shlqbi_lfsr", odd_pipe_pkg::SHLQBI, '0);
        add_lfsr("shlqby_lfsr", odd_pipe_pkg::SHLQBY, '0);
        add_entry("rotqby_reg", odd_pipe_pkg::ROTQBY, pat_a, word0(32'h34), '0, '0, '0, '0,
                  128'h4455_6677_8899_aabb_ccdd_eeff_0011_2233);
        add_lfsr("rotqbi_lfsr", odd_pipe_pkg::ROTQBI, '0);
        add_lfsr("rotqbii_lfsr", odd_pipe_pkg::ROTQBII, 7'h7d);
        add_lfsr("rotqbyi_lfsr", odd_pipe_pkg::ROTQBYI, 7'h1b);
        // Stores and loads interleaved with permutes
        add_entry("stqd", odd_pipe_pkg::STQD, word0(32'h100), '0, c1, '0, 10'h003, '0, c1);
        add_entry("lqa_after_stqd", odd_pipe_pkg::LQA, '0, '0, '0, '0, '0, 16'h004c, c1);
        add_lfsr("rotqby_lfsr", odd_pipe_pkg::ROTQBY, '0);
        add_entry("stqx", odd_pipe_pkg::STQX, word0(32'h200), word0(32'h45), c2, '0, '0, '0, c2);
        add_lfsr("shlqbyi_lfsr", odd_pipe_pkg::SHLQBYI, 7'h0c);
        add_entry("stqa", odd_pipe_pkg::STQA, '0, '0, c3, '0, '0, 16'h3ff0, c3);
        add_entry("shufb", odd_pipe_pkg::SHUFB, pat_a, pat_b,
                  128'h000f_101f_80bf_c0df_e0ff_0315_277a_416e, '0, '0, '0,
                  128'h00ff_0110_0000_ffff_8080_3306_770b_11ee);
        add_entry("lqd_of_stqx", odd_pipe_pkg::LQD, word0(32'h280), '0, '0, '0, 10'h3fc, '0, c2);
        add_lfsr("rotqbi_lfsr_2", odd_pipe_pkg::ROTQBI, '0);
        add_entry("lqx_of_stqd", odd_pipe_pkg::LQX, word0(32'h100), word0(32'h3f), '0, '0, '0, '0,
                  c1);
        add_lfsr("shlqbybi_lfsr", odd_pipe_pkg::SHLQBYBI, '0);
        // Address above the store size wraps onto the line written by stqa
        add_entry("lqd_of_stqa", odd_pipe_pkg::LQD, word0(32'h0001_0f80), '0,
                  '0, '0, 10'h004, '0, c3);
    endtask

    task automatic check_result(input string name, input odd_pipe_pkg::result_t expected,
                                input odd_pipe_pkg::result_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        odd_pipe_pkg::result_t perm_exp;
        odd_pipe_pkg::result_t ls_exp;
        odd_pipe_pkg::result_t act;
        string name;
        int n;
        reset = 1'b1;
        opcode = odd_pipe_pkg::NOP;
        ra = '0;
        rb = '0;
        rc = '0;
        imm7 = '0;
        imm10 = '0;
        imm16 = '0;
        rt_addr = '0;
        unit_id = '0;
        errors = 0;
        checks = 0;
        lfsr_state = 32'h61c7_6cb0;
        build_table();
        n = tab_name.size();
        cycle_limit = 4 * n + 20;
        // Outputs stay zero until the first results arrive
        for (int i = 0; i < odd_pipe_pkg::PERM_LATENCY; i++) begin
            perm_q.push_back('0);
            perm_names.push_back("perm after reset");
        end
        for (int i = 0; i < odd_pipe_pkg::LS_LATENCY; i++) begin
            ls_q.push_back('0);
            ls_names.push_back("ls after reset");
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (int c = 0; c < n + odd_pipe_pkg::LS_LATENCY; c++) begin
            @(posedge clk);
            perm_exp = '0;
            ls_exp = '0;
            name = "idle";
            if (c < n) begin
                name = tab_name[c];
                opcode <= tab_op[c];
                ra <= tab_ra[c];
                rb <= tab_rb[c];
                rc <= tab_rc[c];
                imm7 <= tab_imm7[c];
                imm10 <= tab_imm10[c];
                imm16 <= tab_imm16[c];
                rt_addr <= 7'(c + 3);
                unit_id <= 3'(c);
                if (is_perm_op(tab_op[c])) begin
                    perm_exp = {3'(c), 1'b1, 7'(c + 3), tab_exp[c]};
                end else if (is_load_op(tab_op[c])) begin
                    ls_exp = {3'(c), 1'b1, 7'(c + 3), tab_exp[c]};
                end else if (is_store_op(tab_op[c])) begin
                    ls_exp = {3'(c), 1'b0, 7'(c + 3), tab_exp[c]};
                end
            end else begin
                opcode <= odd_pipe_pkg::NOP;
            end
            perm_q.push_back(perm_exp);
            perm_names.push_back({"perm ", name});
            ls_q.push_back(ls_exp);
            ls_names.push_back({"ls ", name});
            @(negedge clk);
            act = {perm_unit_id, perm_wr_en, perm_rt_addr, perm_data};
            check_result(perm_names.pop_front(), perm_q.pop_front(), act);
            act = {ls_unit_id, ls_wr_en, ls_rt_addr, ls_data};
            check_result(ls_names.pop_front(), ls_q.pop_front(), act);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
